/* src/ifu_cfg_pkg.sv */
// Configuration defaults shared by the fetch unit and its testbench
// Instruction word is fixed at 32 bits; compressed forms use the lower half

package ifu_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////////////////////////

  // One fetch returns one full word
  localparam int INSTR_W = 32;

  typedef logic [INSTR_W-1:0] instr_t;

  ////////////////////////////////////////////////////////////
  // Address width
  ////////////////////////////////////////////////////////////

  // Default PC width, overridden from the top level (16 to 32)
  localparam int PC_W_DEFAULT = 32;

endpackage

/* src/ifu_isa_pkg.sv */
// RV32IC encodings needed by the fetch predecoder
// Only JAL, conditional branches, C.J, C.BEQZ and C.BNEZ are recognized
// JALR and C.JAL are treated as plain sequential instructions

package ifu_isa_pkg;

  ////////////////////////////////////////////////////////////
  // 32-bit encodings
  ////////////////////////////////////////////////////////////

  // Low two bits of a 32-bit instruction
  localparam logic [1:0] LEN_MASK_32 = 2'b11;

  // Major opcodes, bits [6:0]
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  ////////////////////////////////////////////////////////////
  // Compressed encodings
  ////////////////////////////////////////////////////////////

  // Quadrant 1 holds the compressed jumps and branches
  localparam logic [1:0] C_QUAD1 = 2'b01;

  // C.J uses funct3 = 101
  localparam logic [2:0] C_J_FUNCT = 3'b101;

  // C.BEQZ (110) and C.BNEZ (111) share the upper two funct3 bits
  localparam logic [1:0] C_BRANCH_FUNCT = 2'b11;

  ////////////////////////////////////////////////////////////
  // Predecode result
  ////////////////////////////////////////////////////////////

  localparam int OFST_W = 32;

  typedef struct packed {
    logic              rv32;   // 32-bit instruction
    logic              taken;  // Jump, or branch with negative offset
    logic [OFST_W-1:0] ofst;   // Sign-extended target offset
  } pdec_t;

endpackage

/* src/ifu_ctrl_if.sv */
// Fetch-control events, computed once in the control stage
// All members are single-cycle combinational strobes or flag copies

`timescale 1ns/1ps

interface ifu_ctrl_if;

  logic req_hsk;     // Fetch request transferred
  logic rsp_hsk;     // Fetch response transferred
  logic flush_now;   // External flush present this cycle
  logic flush_pend;  // Accepted flush whose redirect has not gone out
  logic reset_req;   // First fetch after reset is due

  // Producer side
  modport ctrl (output req_hsk, rsp_hsk, flush_now, flush_pend, reset_req);

  // PC generation needs every event
  modport pc (input req_hsk, rsp_hsk, flush_now, flush_pend, reset_req);

  // IR stage only cares about responses and flushes
  modport ir (input rsp_hsk, flush_now, flush_pend);

endinterface

/* src/ifu_predecode.sv */
// Combinational predecoder on the raw fetch response
// Output is only meaningful in a cycle where a response is valid

`timescale 1ns/1ps

module ifu_predecode
  import ifu_cfg_pkg::*;
  import ifu_isa_pkg::*;
(
  input  instr_t instr,
  output pdec_t  pdec
);

  logic              is_rv32;
  logic              is_jal;
  logic              is_bxx;
  logic              is_cj;
  logic              is_cbxx;
  logic [OFST_W-1:0] jal_imm;
  logic [OFST_W-1:0] bxx_imm;
  logic [OFST_W-1:0] cj_imm;
  logic [OFST_W-1:0] cb_imm;
  logic [OFST_W-1:0] ofst;

  ////////////////////////////////////////////////////////////
  // Length and type
  ////////////////////////////////////////////////////////////

  assign is_rv32 = (instr[1:0] == LEN_MASK_32);
  assign is_jal  = is_rv32 & (instr[6:0] == OPC_JAL);
  assign is_bxx  = is_rv32 & (instr[6:0] == OPC_BRANCH);

  // Quadrant 1, funct3 in bits [15:13]
  assign is_cj   = (instr[1:0] == C_QUAD1) & (instr[15:13] == C_J_FUNCT);
  assign is_cbxx = (instr[1:0] == C_QUAD1) & (instr[15:14] == C_BRANCH_FUNCT);

  ////////////////////////////////////////////////////////////
  // Immediates, all sign-extended from bit 31 or bit 12
  ////////////////////////////////////////////////////////////

  // J-type
  assign jal_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  // B-type
  assign bxx_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  // CJ format, offset[11|4|9:8|10|6|7|3:1|5]
  assign cj_imm  = {{21{instr[12]}}, instr[8], instr[10:9], instr[6], instr[7],
                    instr[2], instr[11], instr[5:3], 1'b0};
  // CB format, offset[8|4:3] and [7:6|2:1|5]
  assign cb_imm  = {{24{instr[12]}}, instr[6:5], instr[2], instr[11:10],
                    instr[4:3], 1'b0};

  always_comb begin
    ofst = '0;
    if (is_jal) ofst = jal_imm;
    if (is_bxx) ofst = bxx_imm;
    if (is_cj)  ofst = cj_imm;
    if (is_cbxx) ofst = cb_imm;
  end

  // Jumps always taken, branches only backward
  assign pdec.rv32  = is_rv32;
  assign pdec.taken = is_jal | is_cj | ((is_bxx | is_cbxx) & ofst[OFST_W-1]);
  assign pdec.ofst  = ofst;

endmodule

/* src/ifu_fetch_ctrl.sv */
// Fetch-bus control with a single outstanding request
// Flush is always acknowledged; a flush the bus cannot take is held pending
// Halt waits for the outstanding response to be valid before acknowledging

`timescale 1ns/1ps

module ifu_fetch_ctrl (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_ready,
  input  logic     rsp_valid,
  input  logic     flush_req,
  input  logic     halt_req,
  input  logic     ir_ready,
  output logic     req_valid,
  output logic     rsp_ready,
  output logic     halt_ack,
  ifu_ctrl_if.ctrl ctrl
);

  logic reset_flag;
  logic reset_req_r;
  logic flush_pend_r;
  logic out_flag;
  logic halt_ack_r;
  logic flush_any;
  logic fetch_hold;
  logic new_req;
  logic no_outs;

  ////////////////////////////////////////////////////////////
  // Handshakes and request conditions
  ////////////////////////////////////////////////////////////

  assign ctrl.req_hsk    = req_valid & req_ready;
  assign ctrl.rsp_hsk    = rsp_valid & rsp_ready;
  assign ctrl.flush_now  = flush_req;
  assign ctrl.flush_pend = flush_pend_r;
  assign ctrl.reset_req  = reset_req_r;

  assign flush_any  = flush_req | flush_pend_r;
  // Stay quiet until halt_ack has dropped again
  assign fetch_hold = halt_req | halt_ack_r;
  assign new_req    = ~reset_flag & ~fetch_hold;
  // A valid response means the last request has come back
  assign no_outs    = ~out_flag | rsp_valid;

  // Flushed responses are always dropped; otherwise accept only
  // together with the next request
  assign rsp_ready = flush_any | (out_flag & ir_ready & req_ready & ~fetch_hold);

  // Next request once the outstanding one is gone or leaving
  assign req_valid = (new_req | reset_req_r | flush_any) & (~out_flag | ctrl.rsp_hsk);

  ////////////////////////////////////////////////////////////
  // Control flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reset_flag   <= 1'b1;
      reset_req_r  <= 1'b0;
      flush_pend_r <= 1'b0;
      out_flag     <= 1'b0;
      halt_ack_r   <= 1'b0;
    end else begin
      reset_flag <= 1'b0;
      // Reset fetch raised on the first cycle out of reset
      if (reset_flag) begin
        reset_req_r <= 1'b1;
      end else if (ctrl.req_hsk) begin
        reset_req_r <= 1'b0;
      end
      // A flush not issued this cycle is remembered, new flush wins
      if (flush_req & ~ctrl.req_hsk) begin
        flush_pend_r <= 1'b1;
      end else if (ctrl.req_hsk) begin
        flush_pend_r <= 1'b0;
      end
      // Set wins over clear when both transfer together
      if (ctrl.req_hsk) begin
        out_flag <= 1'b1;
      end else if (ctrl.rsp_hsk) begin
        out_flag <= 1'b0;
      end
      if (halt_req & ~halt_ack_r & no_outs) begin
        halt_ack_r <= 1'b1;
      end else if (halt_ack_r & ~halt_req) begin
        halt_ack_r <= 1'b0;
      end
    end
  end

  assign halt_ack = halt_ack_r;

endmodule

/* src/ifu_pc_gen.sv */
// Next fetch address, one shared adder behind an operand mux
// Prediction only counts in a cycle where the response is accepted
// Result always has bit 0 cleared

`timescale 1ns/1ps

module ifu_pc_gen
  import ifu_cfg_pkg::*;
  import ifu_isa_pkg::*;
#(
  parameter int PC_W = PC_W_DEFAULT
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [PC_W-1:0] pc_rtvec,
  input  logic [PC_W-1:0] flush_op1,
  input  logic [PC_W-1:0] flush_op2,
  input  pdec_t           pdec,
  ifu_ctrl_if.pc          ctrl,
  output logic [PC_W-1:0] req_pc,
  output logic [PC_W-1:0] pc
);

  logic            bjp_req;
  logic [PC_W-1:0] incr;
  logic [PC_W-1:0] add_op1;
  logic [PC_W-1:0] add_op2;
  logic [PC_W-1:0] pc_sum;

  assign bjp_req = pdec.taken & ctrl.rsp_hsk;
  // Compressed instructions step by 2
  assign incr    = pdec.rv32 ? PC_W'(4) : PC_W'(2);

  ////////////////////////////////////////////////////////////
  // Operand select in priority order
  ////////////////////////////////////////////////////////////

  always_comb begin
    add_op1 = pc;
    add_op2 = incr;
    if (ctrl.flush_now) begin
      add_op1 = flush_op1;
      add_op2 = flush_op2;
    end else if (ctrl.flush_pend) begin
      // PC already holds the flush target
      add_op2 = '0;
    end else if (bjp_req) begin
      add_op2 = pdec.ofst[PC_W-1:0];
    end else if (ctrl.reset_req) begin
      add_op1 = pc_rtvec;
      add_op2 = '0;
    end
  end

  assign pc_sum = add_op1 + add_op2;
  assign req_pc = {pc_sum[PC_W-1:1], 1'b0};

  // Tracks the request in flight, or the pending flush target
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (ctrl.req_hsk | ctrl.flush_now) begin
      pc <= req_pc;
    end
  end

endmodule

/* src/ifu_ir_stage.sv */
// Instruction register stage with valid/ready toward the decoder
// Upper IR half only loads for 32-bit instructions

`timescale 1ns/1ps

module ifu_ir_stage
  import ifu_cfg_pkg::*;
  import ifu_isa_pkg::*;
#(
  parameter int PC_W = PC_W_DEFAULT
) (
  input  logic            clk,
  input  logic            rst_n,
  input  instr_t          rsp_instr,
  input  logic            rsp_err,
  input  pdec_t           pdec,
  input  logic [PC_W-1:0] pc,
  input  logic            o_ready,
  ifu_ctrl_if.ir          ctrl,
  output logic            ir_ready,
  output logic            o_valid,
  output instr_t          o_ir,
  output logic [PC_W-1:0] o_pc,
  output logic            o_prdt_taken,
  output logic            o_buserr
);

  localparam int HALF_W = INSTR_W / 2;

  logic              valid_set;
  logic              valid_clr;
  logic [HALF_W-1:0] ir_hi;
  logic [HALF_W-1:0] ir_lo;

  // Responses during a flush are dropped
  assign valid_set = ctrl.rsp_hsk & ~ctrl.flush_now & ~ctrl.flush_pend;
  assign valid_clr = o_valid & (o_ready | ctrl.flush_now);
  // Empty or being drained this cycle
  assign ir_ready  = ~o_valid | valid_clr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else if (valid_set) begin
      o_valid <= 1'b1;
    end else if (valid_clr) begin
      o_valid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (valid_set) begin
      ir_lo        <= rsp_instr[HALF_W-1:0];
      o_pc         <= pc;
      o_buserr     <= rsp_err;
      o_prdt_taken <= pdec.taken;
    end
    // Saves toggling the upper half on compressed code
    if (valid_set & pdec.rv32) begin
      ir_hi <= rsp_instr[INSTR_W-1:HALF_W];
    end
  end

  assign o_ir = {ir_hi, ir_lo};

endmodule

/* src/ifu_top.sv */
// Fetch front end top level, plain ports only
// One request outstanding at a time, responses returned in order

`timescale 1ns/1ps

module ifu_top
  import ifu_cfg_pkg::*;
  import ifu_isa_pkg::*;
#(
  parameter int PC_W = PC_W_DEFAULT
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [PC_W-1:0] pc_rtvec,
  // Fetch bus
  output logic            req_valid,
  input  logic            req_ready,
  output logic [PC_W-1:0] req_pc,
  input  logic            rsp_valid,
  output logic            rsp_ready,
  input  instr_t          rsp_instr,
  input  logic            rsp_err,
  // Downstream
  output logic            o_valid,
  input  logic            o_ready,
  output instr_t          o_ir,
  output logic [PC_W-1:0] o_pc,
  output logic            o_prdt_taken,
  output logic            o_buserr,
  // Flush and halt
  input  logic            flush_req,
  output logic            flush_ack,
  input  logic [PC_W-1:0] flush_op1,
  input  logic [PC_W-1:0] flush_op2,
  input  logic            halt_req,
  output logic            halt_ack
);

  logic            ir_ready;
  logic [PC_W-1:0] pc;
  pdec_t           pdec;

  ifu_ctrl_if ctrl_if ();

  // Flush never stalls the pipeline
  assign flush_ack = 1'b1;

  ifu_fetch_ctrl u_fetch_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .flush_req (flush_req),
    .halt_req  (halt_req),
    .ir_ready  (ir_ready),
    .req_valid (req_valid),
    .rsp_ready (rsp_ready),
    .halt_ack  (halt_ack),
    .ctrl      (ctrl_if.ctrl)
  );

  ifu_predecode u_predecode (
    .instr (rsp_instr),
    .pdec  (pdec)
  );

  ifu_pc_gen #(.PC_W(PC_W)) u_pc_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_rtvec  (pc_rtvec),
    .flush_op1 (flush_op1),
    .flush_op2 (flush_op2),
    .pdec      (pdec),
    .ctrl      (ctrl_if.pc),
    .req_pc    (req_pc),
    .pc        (pc)
  );

  ifu_ir_stage #(.PC_W(PC_W)) u_ir_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .rsp_instr    (rsp_instr),
    .rsp_err      (rsp_err),
    .pdec         (pdec),
    .pc           (pc),
    .o_ready      (o_ready),
    .ctrl         (ctrl_if.ir),
    .ir_ready     (ir_ready),
    .o_valid      (o_valid),
    .o_ir         (o_ir),
    .o_pc         (o_pc),
    .o_prdt_taken (o_prdt_taken),
    .o_buserr     (o_buserr)
  );

endmodule

/* tb/ifu_assert.sv */
// Protocol assertions on the fetch-bus control stage
// Checked only while out of reset

`timescale 1ns/1ps

module ifu_assert (
  input logic clk,
  input logic rst_n,
  input logic req_valid,
  input logic req_ready,
  input logic rsp_valid,
  input logic rsp_ready,
  input logic halt_req,
  input logic halt_ack,
  input logic out_flag,
  input logic flush_req,
  input logic flush_pend
);

  a_req_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(req_valid))
    else $error("req_valid is unknown");

  // Halted front end issues nothing
  a_halt_noreq: assert property (@(posedge clk) disable iff (!rst_n)
    halt_ack |-> !(req_valid && req_ready))
    else $error("request transferred while halt_ack was high");

  a_rsp_outs: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && rsp_ready) |-> out_flag)
    else $error("response transferred with no request outstanding");

  // Halt blocks new fetches already before it is acknowledged
  a_halt_noraise: assert property (@(posedge clk) disable iff (!rst_n)
    (halt_req && !flush_req && !flush_pend) |-> !req_valid)
    else $error("request raised while halt_req was high");

endmodule

bind ifu_fetch_ctrl ifu_assert u_assert (
  .clk (clk), .rst_n (rst_n), .req_valid (req_valid), .req_ready (req_ready),
  .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .halt_req (halt_req),
  .halt_ack (halt_ack), .out_flag (out_flag), .flush_req (flush_req),
  .flush_pend (flush_pend_r)
);

/* tb/ifu_tb.sv */
// Random-stimulus testbench for the fetch front end, fixed LFSR seed
// Memory is a hash of the address; the model follows the static prediction rule
// Flushes are only issued with o_ready low and never during a halt

`timescale 1ns/1ps

module ifu_tb
  import ifu_cfg_pkg::*;
  import ifu_isa_pkg::*;
;

  localparam int PC_W  = PC_W_DEFAULT;
  localparam int N_OUT = 1500;
  // About four cycles per output, timeout at four times that
  localparam int N_CYC = 4 * N_OUT;
  localparam int LIMIT = 4 * N_CYC + 200;
  localparam logic [PC_W-1:0] RTVEC = PC_W'(32'h0000_1003);

  logic clk, rst_n, req_ready, rsp_valid, rsp_err, o_ready, flush_req, halt_req;
  logic req_valid, rsp_ready, o_valid, o_prdt_taken, o_buserr, flush_ack, halt_ack;
  logic [PC_W-1:0] pc_rtvec, req_pc, o_pc, flush_op1, flush_op2;
  instr_t rsp_instr, o_ir;

  logic [31:0] lfsr = 32'hdbd77fc1;
  logic [PC_W-1:0] pend_q[$];
  logic err_of [logic [PC_W-1:0]];
  logic [PC_W-1:0] exp_pc, prev_pc;
  logic [15:0] prev_hi;
  instr_t ew, ei, prev_ir;
  pdec_t ep, gp;
  logic hi_known, prev_hold, showing, flush_go, flush_busy, halt_seen;
  int mism, other, cyc, out_cnt, wait_cnt, halt_left, flush_cnt, halt_cnt, bp_left;

  ifu_top #(.PC_W(PC_W)) UUT (.*);

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random source and memory image
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] hash(input logic [31:0] a);
    logic [31:0] h;
    h = (a ^ (a >> 13)) * 32'h9e3779b1;
    return h ^ (h >> 16);
  endfunction

  // Small even offset from -128 to +126
  function automatic logic [31:0] offset_of(input logic [31:0] h);
    return {{24{h[23]}}, h[23:17], 1'b0};
  endfunction

  // Kind picked by h[2:0] as 0-2 addi, 3 c.addi, 4 jal, 5 c.j, 6 bne, 7 c.beqz/c.bnez
  function automatic instr_t mem_word(input logic [31:0] a);
    logic [31:0] h;
    logic [31:0] o;
    h = hash(a);
    o = offset_of(h);
    case (h[2:0])
      3'd3: return {h[31:16], 3'b000, h[12:2], 2'b01};
      3'd4: return {o[20], o[10:1], o[11], o[19:12], h[11:7], 7'b1101111};
      3'd5: return {h[31:16], 3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1],
                    o[5], 2'b01};
      3'd6: return {o[12], o[10:5], h[28:24], h[14:10], 3'b001, o[4:1], o[11], 7'b1100011};
      3'd7: return {h[31:16], 2'b11, h[3], o[8], o[4:3], h[9:7], o[7:6], o[2:1], o[5], 2'b01};
      default: return {h[31:20], h[19:15], 3'b000, h[11:7], 7'b0010011};
    endcase
  endfunction

  // Expected length and prediction, taken from the generator's choice of kind
  function automatic pdec_t mem_pdec(input logic [31:0] a);
    logic [31:0] h;
    pdec_t p;
    h = hash(a);
    p.rv32  = h[2:0] inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd6};
    p.ofst  = (h[2:0] >= 3'd4) ? offset_of(h) : '0;
    p.taken = (h[2:0] inside {3'd4, 3'd5}) || ((h[2:0] >= 3'd6) && p.ofst[31]);
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_pc(input string what, input logic [PC_W-1:0] got, exp);
    if (got !== exp) begin
      mism++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_instr(input string what, input instr_t got, exp);
    if (got !== exp) begin
      mism++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Offset is not visible at the outputs, it shows up in the next o_pc
  task automatic check_pdec(input pdec_t got, exp);
    if ({got.rv32, got.taken} !== {exp.rv32, exp.taken}) begin
      mism++;
      $display("mismatch at %0t: rv32/taken got %b%b expected %b%b", $time,
               got.rv32, got.taken, exp.rv32, exp.taken);
    end
  endtask

  task automatic check_flag(input string what, input logic got, exp);
    if (got !== exp) begin
      mism++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Model, memory responder and stimulus
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      cyc++;
      // Held output must not move
      if (prev_hold) begin
        if (!o_valid) begin
          other++;
          $display("o_valid dropped at %0t while o_ready was low", $time);
        end
        check_instr("held o_ir", o_ir, prev_ir);
        check_pc("held o_pc", o_pc, prev_pc);
      end
      prev_hold = o_valid && !o_ready && !flush_req;
      prev_ir   = o_ir;
      prev_pc   = o_pc;
      if (o_valid && o_ready) begin
        ew = mem_word(exp_pc);
        ep = mem_pdec(exp_pc);
        check_pc("o_pc", o_pc, exp_pc);
        if (ep.rv32 || hi_known) begin
          // Compressed word keeps the upper half of the last 32-bit word loaded
          ei = ep.rv32 ? ew : {prev_hi, ew[15:0]};
          check_instr("o_ir", o_ir, ei);
        end else begin
          // No 32-bit word loaded yet, so only the lower half is defined
          check_instr("o_ir lower half", {16'h0, o_ir[15:0]}, {16'h0, ew[15:0]});
        end
        gp       = '0;
        gp.rv32  = (o_ir[1:0] == 2'b11);
        gp.taken = o_prdt_taken;
        check_pdec(gp, ep);
        check_flag("o_buserr", o_buserr, err_of.exists(exp_pc) ? err_of[exp_pc] : 1'b0);
        if (ep.rv32) begin
          prev_hi  = ew[31:16];
          hi_known = 1'b1;
        end
        exp_pc = ep.taken ? exp_pc + ep.ofst[PC_W-1:0]
                          : exp_pc + (ep.rv32 ? PC_W'(4) : PC_W'(2));
        out_cnt++;
      end
      if (flush_req) begin
        check_flag("flush_ack", flush_ack, 1'b1);
        // A held output dropped by the flush still loaded its upper half
        if (o_valid) begin
          ep = mem_pdec(exp_pc);
          if (ep.rv32) begin
            ew       = mem_word(exp_pc);
            prev_hi  = ew[31:16];
            hi_known = 1'b1;
          end
        end
        exp_pc = (flush_op1 + flush_op2) & ~PC_W'(1);
      end
      if (halt_ack && req_valid && req_ready) begin
        other++;
        $display("request transferred at %0t while halt_ack was high", $time);
      end
      // Responder, one answer per request in order
      if (rsp_valid && rsp_ready) begin
        err_of[pend_q[0]] = rsp_err;
        void'(pend_q.pop_front());
        showing = 1'b0;
        rsp_valid <= 1'b0;
      end
      if (req_valid && req_ready) begin
        pend_q.push_back(req_pc);
        wait_cnt   = rnd(2);
        flush_busy = 1'b0;
      end
      if (!showing && pend_q.size() > 0) begin
        if (wait_cnt == 0) begin
          showing = 1'b1;
          rsp_valid <= 1'b1;
          rsp_instr <= mem_word(pend_q[0]);
          rsp_err   <= (rnd(4) == 0);
        end else begin
          wait_cnt--;
        end
      end
      req_ready <= (rnd(2) != 0);
      // Flush with o_ready low and never near a halt
      flush_go = (halt_left == 0) && !halt_ack && cyc > 40 && (rnd(5) == 0);
      flush_req <= flush_go;
      if (flush_go) begin
        flush_op1 <= PC_W'(32'h2000) + PC_W'(rnd(12));
        flush_op2 <= PC_W'(rnd(6));
        flush_busy = 1'b1;
        flush_cnt++;
      end
      if (halt_left > 0) begin
        if (halt_ack) halt_seen = 1'b1;
        halt_left--;
        if (halt_left == 0) begin
          halt_req <= 1'b0;
          if (!halt_seen) begin
            other++;
            $display("halt_req was not acknowledged by %0t", $time);
          end
        end
      end else if (!flush_go && !flush_busy && !halt_ack && cyc > 40 && rnd(6) == 0) begin
        halt_req <= 1'b1;
        halt_left = 10 + rnd(3);
        halt_seen = 1'b0;
        halt_cnt++;
      end
      // Back-pressure bursts
      if (bp_left > 0) bp_left--;
      else if (rnd(5) == 0) bp_left = rnd(3);
      o_ready <= !flush_go && bp_left == 0 && (rnd(3) != 0);
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    pc_rtvec = RTVEC;
    req_ready = 1'b0;
    rsp_valid = 1'b0;
    rsp_instr = '0;
    rsp_err = 1'b0;
    o_ready = 1'b0;
    flush_req = 1'b0;
    flush_op1 = '0;
    flush_op2 = '0;
    halt_req = 1'b0;
    exp_pc = RTVEC & ~PC_W'(1);
    {hi_known, prev_hold, showing, flush_busy, halt_seen} = '0;
    {mism, other, cyc, out_cnt, wait_cnt, halt_left, flush_cnt, halt_cnt, bp_left} = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (req_valid || rsp_ready || o_valid || halt_ack) begin
      other++;
      $display("outputs not idle in the first cycle after reset");
    end
    @(posedge clk);
    if (!req_valid) begin
      other++;
      $display("first request was not raised in the second cycle after reset");
    end
    check_pc("first req_pc", req_pc, RTVEC & ~PC_W'(1));
    while (out_cnt < N_OUT && cyc < LIMIT) @(posedge clk);
    if (cyc >= LIMIT) begin
      other++;
      $display("timeout after %0d cycles with %0d outputs seen", cyc, out_cnt);
    end
    if (flush_cnt == 0 || halt_cnt == 0) begin
      other++;
      $display("run ended without exercising both flush and halt");
    end
    $display("Outputs %0d, mismatches %0d, other failures %0d", out_cnt, mism, other);
    if (mism == 0 && other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* files.f */
src/ifu_cfg_pkg.sv
src/ifu_isa_pkg.sv
src/ifu_ctrl_if.sv
src/ifu_predecode.sv
src/ifu_fetch_ctrl.sv
src/ifu_pc_gen.sv
src/ifu_ir_stage.sv
src/ifu_top.sv
tb/ifu_assert.sv
tb/ifu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module ifu_tb -o ifu_sim
status=0
./obj_dir/ifu_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -qF "*** TEST FAILED ***" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
